// File: logic/axis_pkg.sv
// axis_pkg: input stream widths, stored beat layout and packet FIFO sizing
package axis_pkg;

    // ****************************************
    // stream geometry
    // ****************************************
    // bytes per stream beat
    localparam int AXIS_BYTES = 16;

    // beat payload and byte enables
    typedef logic [AXIS_BYTES*8-1:0] axis_data_t;
    typedef logic [AXIS_BYTES-1:0]   axis_keep_t;

    // invalid bytes in a tail beat, 0..15
    typedef logic [3:0] byte_cnt_t;

    // one accepted beat as held in the packet FIFO
    typedef struct packed {
        axis_data_t data;
        logic       last;
        byte_cnt_t  inv_cnt;
    } beat_t;

    // ****************************************
    // FIFO sizing and packet rules
    // ****************************************
    localparam int FIFO_DEPTH  = 256;
    // fill counter, must hold FIFO_DEPTH itself
    localparam int FIFO_CNT_W  = 9;
    // tready drops here, half of the depth
    localparam int READY_LIMIT = 128;

    // set in the first beat of a command packet
    localparam int PKT_TYPE_BIT = 127;
    // leading data-packet words that pass without byte swap
    localparam int META_WORDS   = 2;

endpackage

// File: logic/fast_bus_pkg.sv
// fast_bus_pkg: output word layout, position tags and framer states of the fast bus
package fast_bus_pkg;

    // ****************************************
    // fast bus word
    // ****************************************
    // position tag in the two top bits of every word
    typedef enum logic [1:0] {
        // first word of a packet
        TAG_HEAD = 2'b01,
        // any word between head and tail
        TAG_BODY = 2'b11,
        // last word, carries the invalid-byte count
        TAG_TAIL = 2'b10
    } pos_tag_e;

    // 2 + 4 + 128 = 134 bits on the bus
    typedef struct packed {
        pos_tag_e              tag;
        // nonzero only with TAG_TAIL
        axis_pkg::byte_cnt_t   inv_cnt;
        axis_pkg::axis_data_t  data;
    } fast_word_t;

    // ****************************************
    // framer control
    // ****************************************
    // IDLE   wait for a complete packet and a ready receiver
    // HEAD   first word, never swapped
    // META   remaining metadata words of a data packet
    // BODY   payload words up to and including the tail
    typedef enum logic [1:0] {
        IDLE,
        HEAD,
        META,
        BODY
    } framer_state_e;

endpackage

// File: logic/axis_ingress.sv
// axis_ingress: accepts stream beats into beat records and throttles tready on FIFO fill
`timescale 1ns/1ps

module axis_ingress import axis_pkg::*; (
    input  logic                  aclk,
    input  logic                  aresetn,
    input  logic                  s_axi_tvalid,
    input  axis_data_t            s_axi_tdata,
    input  logic                  s_axi_tlast,
    input  axis_keep_t            s_axi_tkeep,
    input  logic [FIFO_CNT_W-1:0] fill,
    output logic                  s_axi_tready,
    output logic                  wr_en,
    output beat_t                 wr_beat
);

    logic      accept;
    byte_cnt_t inv_cnt;

    // handshake on this edge
    assign accept = s_axi_tvalid && s_axi_tready;

    // ****************************************
    // tkeep to invalid-byte count
    // ****************************************
    // keep is contiguous from bit 0, so zero bits = missing bytes
    always_comb begin
        inv_cnt = '0;
        if (s_axi_tlast) begin
            for (int i = 0; i < AXIS_BYTES; i++) begin
                if (!s_axi_tkeep[i]) begin
                    inv_cnt = inv_cnt + 1'b1;
                end
            end
        end
    end

    // ****************************************
    // flow control and write strobe
    // ****************************************
    // tready registered, low through reset
    // a couple of in-flight beats past the limit are fine, FIFO is twice as deep
    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            s_axi_tready <= 1'b0;
            wr_en        <= 1'b0;
        end else begin
            s_axi_tready <= (fill < FIFO_CNT_W'(READY_LIMIT));
            // write one cycle after acceptance
            wr_en        <= accept;
        end
    end

    // beat record, only meaningful with wr_en
    always_ff @(posedge aclk) begin
        if (accept) begin
            wr_beat.data    <= s_axi_tdata;
            wr_beat.last    <= s_axi_tlast;
            wr_beat.inv_cnt <= inv_cnt;
        end
    end

endmodule

// File: logic/packet_fifo.sv
// packet_fifo: first-word-fall-through beat FIFO with fill level and stored-packet count
`timescale 1ns/1ps

module packet_fifo import axis_pkg::*; #(
    parameter int DEPTH = FIFO_DEPTH
) (
    input  logic                  aclk,
    input  logic                  aresetn,
    input  logic                  wr_en,
    input  beat_t                 wr_beat,
    input  logic                  rd_en,
    output beat_t                 head_beat,
    output logic [FIFO_CNT_W-1:0] fill,
    output logic                  pkt_avail
);

    // DEPTH is a power of two, pointers wrap on their own
    localparam int ADDR_W = $clog2(DEPTH);

    beat_t                 mem [DEPTH];
    logic [ADDR_W-1:0]     wr_ptr;
    logic [ADDR_W-1:0]     rd_ptr;
    logic [FIFO_CNT_W-1:0] pkt_cnt;
    logic                  do_wr;
    logic                  do_rd;
    logic                  wr_tail;
    logic                  rd_tail;

    // guard against overflow and underflow
    assign do_wr = wr_en && (fill != FIFO_CNT_W'(DEPTH));
    assign do_rd = rd_en && (fill != '0);

    // tail beats moving in and out
    assign wr_tail = do_wr && wr_beat.last;
    assign rd_tail = do_rd && head_beat.last;

    // ****************************************
    // storage
    // ****************************************
    always_ff @(posedge aclk) begin
        if (do_wr) begin
            mem[wr_ptr] <= wr_beat;
        end
    end

    // oldest beat shown without read latency
    assign head_beat = mem[rd_ptr];

    // ****************************************
    // pointers and fill level
    // ****************************************
    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            fill   <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // simultaneous push and pop leaves fill unchanged
            case ({do_wr, do_rd})
                2'b10:   fill <= fill + 1'b1;
                2'b01:   fill <= fill - 1'b1;
                default: fill <= fill;
            endcase
        end
    end

    // ****************************************
    // complete packets stored
    // ****************************************
    // up on tail write, down on tail pop
    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            pkt_cnt <= '0;
        end else begin
            case ({wr_tail, rd_tail})
                2'b10:   pkt_cnt <= pkt_cnt + 1'b1;
                2'b01:   pkt_cnt <= pkt_cnt - 1'b1;
                default: pkt_cnt <= pkt_cnt;
            endcase
        end
    end

    // framer may start a packet only when its tail is already stored
    assign pkt_avail = (pkt_cnt != '0);

endmodule

// File: logic/fast_framer.sv
// fast_framer: tags, byte-swaps and emits one fast-bus word per stored beat of a packet
`timescale 1ns/1ps

module fast_framer import axis_pkg::*, fast_bus_pkg::*; (
    input  logic       aclk,
    input  logic       aresetn,
    input  beat_t      head_beat,
    input  logic       pkt_avail,
    input  logic       dma2um_ready,
    output logic       rd_en,
    output logic       dma2um_data_wr,
    output fast_word_t dma2um_data,
    output logic       dma2um_valid_wr,
    output logic       dma2um_valid
);

    // word index wide enough to reach META_WORDS - 1
    localparam int IDX_W = $clog2(META_WORDS + 1);

    framer_state_e    state;
    logic             is_cmd;
    logic [IDX_W-1:0] word_idx;
    logic             tail_now;
    logic             swap_en;
    fast_word_t       nxt_word;

    // reverse byte order across the whole beat
    function automatic axis_data_t byte_swap(input axis_data_t d);
        axis_data_t r;
        for (int i = 0; i < AXIS_BYTES; i++) begin
            r[8*i +: 8] = d[8*(AXIS_BYTES-1-i) +: 8];
        end
        return r;
    endfunction

    // ****************************************
    // word build
    // ****************************************
    // every non-idle state emits and pops exactly one beat
    assign rd_en = (state != IDLE);

    // head beat never ends a packet, min two beats
    assign tail_now = (state == META || state == BODY) && head_beat.last;

    // only payload of data packets is swapped
    assign swap_en = (state == BODY) && !is_cmd;

    always_comb begin
        nxt_word.data    = swap_en ? byte_swap(head_beat.data) : head_beat.data;
        nxt_word.inv_cnt = '0;
        if (state == HEAD) begin
            nxt_word.tag = TAG_HEAD;
        end else if (tail_now) begin
            nxt_word.tag     = TAG_TAIL;
            nxt_word.inv_cnt = head_beat.inv_cnt;
        end else begin
            nxt_word.tag = TAG_BODY;
        end
    end

    // ****************************************
    // state machine and output register
    // ****************************************
    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            state           <= IDLE;
            is_cmd          <= 1'b0;
            word_idx        <= '0;
            dma2um_data_wr  <= 1'b0;
            dma2um_data     <= '0;
            dma2um_valid_wr <= 1'b0;
            dma2um_valid    <= 1'b0;
        end else begin
            // strobes are single cycle
            dma2um_data_wr  <= 1'b0;
            dma2um_data     <= '0;
            dma2um_valid_wr <= 1'b0;
            dma2um_valid    <= 1'b0;

            if (state != IDLE) begin
                dma2um_data_wr <= 1'b1;
                dma2um_data    <= nxt_word;
            end
            // packet valid goes out with the tail word
            if (tail_now) begin
                dma2um_valid_wr <= 1'b1;
                dma2um_valid    <= 1'b1;
            end

            case (state)
                IDLE: begin
                    // ready only looked at here, never mid-packet
                    if (pkt_avail && dma2um_ready) begin
                        is_cmd   <= head_beat.data[PKT_TYPE_BIT];
                        word_idx <= '0;
                        state    <= HEAD;
                    end
                end
                HEAD: begin
                    word_idx <= word_idx + 1'b1;
                    // command packets have no metadata stage
                    state    <= is_cmd ? BODY : META;
                end
                META: begin
                    word_idx <= word_idx + 1'b1;
                    if (tail_now) begin
                        state <= IDLE;
                    end else if (word_idx == IDX_W'(META_WORDS - 1)) begin
                        state <= BODY;
                    end
                end
                BODY: begin
                    if (tail_now) begin
                        state <= IDLE;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

endmodule

// File: logic/dma_axis_to_fast.sv
// dma_axis_to_fast: AXI4-Stream DMA input to fast packet bus, ingress into packet FIFO into framer
`timescale 1ns/1ps

module dma_axis_to_fast import axis_pkg::*, fast_bus_pkg::*; (
    input  logic       aclk,
    input  logic       aresetn,
    // ****************************************
    // AXI4-Stream from DMA
    // ****************************************
    input  logic       s_axi_tvalid,
    input  axis_data_t s_axi_tdata,
    input  logic       s_axi_tlast,
    input  axis_keep_t s_axi_tkeep,
    output logic       s_axi_tready,
    // ****************************************
    // fast bus to user logic
    // ****************************************
    output logic       dma2um_data_wr,
    output fast_word_t dma2um_data,
    output logic       dma2um_valid_wr,
    output logic       dma2um_valid,
    input  logic       dma2um_ready
);

    // ingress to FIFO
    logic                  wr_en;
    beat_t                 wr_beat;
    logic [FIFO_CNT_W-1:0] fill;

    // FIFO to framer
    beat_t                 head_beat;
    logic                  pkt_avail;
    logic                  rd_en;

    axis_ingress u_ingress (
        .aclk         (aclk),
        .aresetn      (aresetn),
        .s_axi_tvalid (s_axi_tvalid),
        .s_axi_tdata  (s_axi_tdata),
        .s_axi_tlast  (s_axi_tlast),
        .s_axi_tkeep  (s_axi_tkeep),
        .fill         (fill),
        .s_axi_tready (s_axi_tready),
        .wr_en        (wr_en),
        .wr_beat      (wr_beat)
    );

    packet_fifo #(
        .DEPTH (FIFO_DEPTH)
    ) u_fifo (
        .aclk      (aclk),
        .aresetn   (aresetn),
        .wr_en     (wr_en),
        .wr_beat   (wr_beat),
        .rd_en     (rd_en),
        .head_beat (head_beat),
        .fill      (fill),
        .pkt_avail (pkt_avail)
    );

    fast_framer u_framer (
        .aclk            (aclk),
        .aresetn         (aresetn),
        .head_beat       (head_beat),
        .pkt_avail       (pkt_avail),
        .dma2um_ready    (dma2um_ready),
        .rd_en           (rd_en),
        .dma2um_data_wr  (dma2um_data_wr),
        .dma2um_data     (dma2um_data),
        .dma2um_valid_wr (dma2um_valid_wr),
        .dma2um_valid    (dma2um_valid)
    );

endmodule

// File: tb/dma_axis_to_fast_asserts.sv
// dma_axis_to_fast_asserts: protocol assertions on the fast bus and the stream ready
`timescale 1ns/1ps

module dma_axis_to_fast_asserts import fast_bus_pkg::*; (
    input logic       aclk,
    input logic       aresetn,
    input logic       s_axi_tready,
    input logic       dma2um_data_wr,
    input fast_word_t dma2um_data,
    input logic       dma2um_valid_wr
);

    // ****************************************
    // fast bus framing
    // ****************************************
    // packet valid only together with a word
    assert property (@(posedge aclk) disable iff (!aresetn)
        dma2um_valid_wr |-> dma2um_data_wr)
        else $error("valid_wr without data_wr");

    // no gap inside a packet, head through tail
    assert property (@(posedge aclk) disable iff (!aresetn)
        (dma2um_data_wr && dma2um_data.tag != TAG_TAIL) |=> dma2um_data_wr)
        else $error("gap inside a packet");

    // invalid-byte count belongs to the tail only
    assert property (@(posedge aclk) disable iff (!aresetn)
        (dma2um_data_wr && dma2um_data.tag != TAG_TAIL) |-> dma2um_data.inv_cnt == '0)
        else $error("nonzero byte count on a non-tail word");

    // stream input closed during reset
    assert property (@(posedge aclk) !aresetn |-> !s_axi_tready)
        else $error("tready high in reset");

endmodule

bind dma_axis_to_fast dma_axis_to_fast_asserts u_asserts (.*);

// File: tb/tb_dma_axis_to_fast.sv
// tb_dma_axis_to_fast: file-driven packet testbench with back-pressure phase for the DMA framer
`timescale 1ns/1ps

module tb_dma_axis_to_fast import axis_pkg::*, fast_bus_pkg::*; ();

    localparam int REC_MAX      = 64;
    localparam int STRESS_PKTS  = 40;
    localparam int STRESS_BEATS = 4;

    logic       aclk = 1'b0;
    logic       aresetn;
    logic       s_axi_tvalid;
    axis_data_t s_axi_tdata;
    logic       s_axi_tlast;
    axis_keep_t s_axi_tkeep;
    logic       s_axi_tready;
    logic       dma2um_data_wr;
    fast_word_t dma2um_data;
    logic       dma2um_valid_wr;
    logic       dma2um_valid;
    logic       dma2um_ready;

    // kind[151:148] a[147:144] b[143:128] data[127:0]
    logic [151:0] recs [REC_MAX];
    logic [151:0] in_q [$];
    fast_word_t   exp_q [$];
    string        test_name;
    int           cycles;
    int           limit;
    int           accepted;
    logic         rand_ready;
    logic         gaps;

    dma_axis_to_fast u_dut (.*);

    always #20 aclk = ~aclk;

    // ****************************************
    // checks
    // ****************************************
    task automatic check_word(input string name, input fast_word_t exp, input fast_word_t act);
        if (act !== exp) begin
            $display("FAILED %s: expected %h, actual %h", name, exp, act);
            $display("*** FAILED ***");
            $fatal(1, "word mismatch");
        end
    endtask

    task automatic check_valid(input string name, input logic [1:0] exp, input logic [1:0] act);
        if (act !== exp) begin
            $display("FAILED %s: expected %b, actual %b", name, exp, act);
            $display("*** FAILED ***");
            $fatal(1, "valid strobe mismatch");
        end
    endtask

    task automatic check_ready(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("FAILED %s: expected %b, actual %b", name, exp, act);
            $display("*** FAILED ***");
            $fatal(1, "tready mismatch");
        end
    endtask

    // run limit from the test length
    always @(posedge aclk) begin
        cycles++;
        if (cycles >= limit) begin
            $display("timeout: packets still pending after %0d cycles", cycles);
            $display("*** FAILED ***");
            $fatal(1, "timeout");
        end
    end

    // receiver ready, random low stretches
    always @(posedge aclk) begin
        #1;
        if (rand_ready) begin
            dma2um_ready = ($urandom % 4) != 0;
        end
    end

    // outputs sampled at the falling edge, between DUT updates
    always @(negedge aclk) begin : monitor
        fast_word_t e;
        logic [1:0] ev;
        ev = 2'b00;
        if (!aresetn) begin
            check_ready("reset", 1'b0, s_axi_tready);
        end else if (dma2um_data_wr) begin
            if (exp_q.size() == 0) begin
                $display("output word %h appeared with no word expected", dma2um_data);
                $display("*** FAILED ***");
                $fatal(1, "unexpected output");
            end
            e = exp_q.pop_front();
            check_word(test_name, e, dma2um_data);
            ev = (e.tag == TAG_TAIL) ? 2'b11 : 2'b00;
        end
        check_valid(test_name, ev, {dma2um_valid_wr, dma2um_valid});
    end

    // ****************************************
    // stimulus
    // ****************************************
    // entered and left at rising edge plus 1 ns
    task automatic send_beat(input logic last, input axis_keep_t keep, input axis_data_t data);
        logic hs;
        if (gaps) begin
            repeat ($urandom % 3) begin
                @(posedge aclk);
                #1;
            end
        end
        s_axi_tvalid = 1'b1;
        s_axi_tlast  = last;
        s_axi_tkeep  = keep;
        s_axi_tdata  = data;
        // tready only moves on an edge
        hs = s_axi_tready;
        @(posedge aclk);
        #1;
        while (!hs) begin
            hs = s_axi_tready;
            @(posedge aclk);
            #1;
        end
        s_axi_tvalid = 1'b0;
        accepted++;
    endtask

    task automatic wait_drain();
        while (exp_q.size() != 0) begin
            @(posedge aclk);
            #1;
        end
    endtask

    // command packets, unswapped, full keep
    task automatic send_stress();
        for (int p = 0; p < STRESS_PKTS; p++) begin
            for (int b = 0; b < STRESS_BEATS; b++) begin
                send_beat(b == STRESS_BEATS - 1, 16'hffff,
                          {8'h80, 8'(p), 8'(b), 104'(p * STRESS_BEATS + b)});
            end
        end
    endtask

    initial begin
        fast_word_t ew;
        void'($urandom(69));
        aresetn      = 1'b0;
        s_axi_tvalid = 1'b0;
        s_axi_tlast  = 1'b0;
        s_axi_tkeep  = '0;
        s_axi_tdata  = '0;
        dma2um_ready = 1'b0;
        rand_ready   = 1'b0;
        gaps         = 1'b0;
        cycles       = 0;
        limit        = 100000;
        accepted     = 0;
        test_name    = "reset";

        for (int i = 0; i < REC_MAX; i++) begin
            recs[i] = '0;
        end
        $readmemh("tb/testdata_packets.txt", recs);
        for (int i = 0; i < REC_MAX; i++) begin
            if (recs[i][151:148] == 4'd1) begin
                in_q.push_back(recs[i]);
            end else if (recs[i][151:148] == 4'd2) begin
                ew.tag     = pos_tag_e'(recs[i][145:144]);
                ew.inv_cnt = recs[i][131:128];
                ew.data    = recs[i][127:0];
                exp_q.push_back(ew);
            end
        end
        if (in_q.size() == 0) begin
            $display("no input beats found in the data file");
            $display("*** FAILED ***");
            $fatal(1, "empty data file");
        end
        // ten cycles per beat, plus reset, idle and stall slack
        limit = 10 * (in_q.size() + STRESS_PKTS * STRESS_BEATS) + 10 + 400;

        repeat (10) @(posedge aclk);
        #1;
        aresetn = 1'b1;

        // quiet bus before any input
        test_name = "idle";
        repeat (5) @(posedge aclk);
        #1;

        test_name  = "file_packets";
        rand_ready = 1'b1;
        gaps       = 1'b1;
        foreach (in_q[i]) begin
            send_beat(in_q[i][144], in_q[i][143:128], in_q[i][127:0]);
        end
        wait_drain();

        // ****************************************
        // back-pressure, receiver held off
        // ****************************************
        test_name  = "backpressure";
        rand_ready = 1'b0;
        gaps       = 1'b0;
        @(posedge aclk);
        #1;
        dma2um_ready = 1'b0;
        for (int p = 0; p < STRESS_PKTS; p++) begin
            for (int b = 0; b < STRESS_BEATS; b++) begin
                ew.tag     = (b == 0) ? TAG_HEAD : (b == STRESS_BEATS - 1) ? TAG_TAIL : TAG_BODY;
                ew.inv_cnt = '0;
                ew.data    = {8'h80, 8'(p), 8'(b), 104'(p * STRESS_BEATS + b)};
                exp_q.push_back(ew);
            end
        end
        accepted = 0;
        fork
            send_stress();
        join_none
        while (accepted < READY_LIMIT) begin
            @(posedge aclk);
            #1;
        end
        repeat (4) @(posedge aclk);
        #1;
        check_ready(test_name, 1'b0, s_axi_tready);
        dma2um_ready = 1'b1;
        wait fork;
        wait_drain();

        repeat (5) @(posedge aclk);
        $display("*** PASSED ***");
        $finish;
    end

endmodule

// File: dma_axis_to_fast.f
logic/axis_pkg.sv
logic/fast_bus_pkg.sv
logic/axis_ingress.sv
logic/packet_fifo.sv
logic/fast_framer.sv
logic/dma_axis_to_fast.sv
tb/dma_axis_to_fast_asserts.sv
tb/tb_dma_axis_to_fast.sv

// File: run_sim.sh
#!/bin/sh
# build and run the testbench with Verilator; exit status is the simulation result
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_dma_axis_to_fast \
    -f dma_axis_to_fast.f \
    -o sim_dma_axis_to_fast

./obj_dir/sim_dma_axis_to_fast

// File: tb/testdata_packets.txt
// kind_a_bbbb_data: kind 1 input (a = tlast, b = tkeep), kind 2 expected (a = tag, b = count)
// tags 1 head, 3 body, 2 tail; data packets swap bytes after the two metadata words
// data packet, 4 beats, full tail
1_0_ffff_0000000000000000000000000000a001
1_0_ffff_0000000000000000000000000000a002
1_0_ffff_00112233445566778899aabbccddeeff
1_1_ffff_0f1e2d3c4b5a69788796a5b4c3d2e1f0
2_1_0000_0000000000000000000000000000a001
2_3_0000_0000000000000000000000000000a002
2_3_0000_ffeeddccbbaa99887766554433221100
2_2_0000_f0e1d2c3b4a5968778695a4b3c2d1e0f
// command packet, 3 beats, eight bytes missing
1_0_ffff_80000000000000000000000000000c01
1_0_ffff_00112233445566778899aabbccddeeff
1_1_00ff_0000000000000000deadbeefcafef00d
2_1_0000_80000000000000000000000000000c01
2_3_0000_00112233445566778899aabbccddeeff
2_2_0008_0000000000000000deadbeefcafef00d
// data packet, 2 beats, tail is metadata
1_0_ffff_0000000000000000000000000000a003
1_1_0fff_00000000aabbccdd0102030405060708
2_1_0000_0000000000000000000000000000a003
2_2_0004_00000000aabbccdd0102030405060708
// data packet, 3 beats, one byte missing
1_0_ffff_0000000000000000000000000000a004
1_0_ffff_0000000000000000000000000000a005
1_1_7fff_000102030405060708090a0b0c0d0e0f
2_1_0000_0000000000000000000000000000a004
2_3_0000_0000000000000000000000000000a005
2_2_0001_0f0e0d0c0b0a09080706050403020100
// command packet, 2 beats, one byte kept
1_0_ffff_80000000000000000000000000000c02
1_1_0001_112233445566778899aabbccddeeff00
2_1_0000_80000000000000000000000000000c02
2_2_000f_112233445566778899aabbccddeeff00
